// File: source/serdes_consts.svh
/* Project-wide constants for the serial loopback design.
   Include this wherever word width, lock or credit values are needed. */

`ifndef SERDES_CONSTS_SVH
`define SERDES_CONSTS_SVH

// ***********************************************************
// Word format
// ***********************************************************
`define SERDES_WIDTH    10          // Bits per word
`define SERDES_CNT_W    4           // Bit counter width, holds 0..WIDTH-1

// ***********************************************************
// Lock detection
// ***********************************************************
`define SETTLE_CYCLES   255         // Power-up settling period in cycles
`define SETTLE_W        8           // Settle counter width
`define TRAIN_WORD      10'h3E0     // Training pattern
`define TRAIN_COUNT     4           // Consecutive training words for lock
`define TRAIN_RUN_W     3           // Run-length counter width

`define CREDIT_DEPTH    2           // Serializer buffer entries
`define SERDES_CREDIT_W 2           // Holds 0..CREDIT_DEPTH
`define SERDES_PTR_W    1           // Buffer pointer width

`endif

// File: source/serdes_word_pkg.sv
/* Data-path types shared by the deserializer and serializer.
   Import wherever a word or a credit pulse crosses a module port. */

`include "serdes_consts.svh"

package serdes_word_pkg;

    // ***********************************************************
    // Word channel
    // ***********************************************************

    // One word on the channel, valid is a single-cycle strobe
    typedef struct packed {
        logic                       valid;  // Word strobe
        logic [`SERDES_WIDTH-1:0]   data;   // MSB is first bit on the wire
    } serdes_word_t;

    // ***********************************************************
    // Credit return
    // ***********************************************************

    // Pulse from the serializer each time a buffer entry frees up.
    // The sender adds one credit per pulse.
    typedef struct packed {
        logic ret;                          // One credit back
    } credit_ret_t;

endpackage

// File: source/serdes_ctrl_pkg.sv
/* Control and status types for the loopback link.
   Import where the registered pin controls or the link status are used. */

package serdes_ctrl_pkg;

    // ***********************************************************
    // Registered pin controls, all active high
    // ***********************************************************
    typedef struct packed {
        logic data;                         // Sampled serial bit
        logic enable;                       // Inverted enable_n
        logic bitslip;                      // One-cycle slip request
    } ctrl_sync_t;

    // ***********************************************************
    // Link status
    // ***********************************************************

    // Ready latches once the link is settled and aligned.
    // Overrun is sticky until reset.
    typedef struct packed {
        logic ready;                        // Link aligned and settled
        logic overrun;                      // A word was dropped
    } link_status_t;

endpackage

// File: source/deser_bitslip.sv
/* Serial-to-parallel converter with one-bit word boundary slip.
   Every aligned word goes to the lock monitor; words are forwarded to
   the serializer only while ready is high and a credit is held. */

`include "serdes_consts.svh"

module deser_bitslip import serdes_word_pkg::*, serdes_ctrl_pkg::*; (
    input  logic         clkGHz_clkbuf,
    input  logic         reset_buf_n,
    input  ctrl_sync_t   ctrl,              // Registered pin controls
    input  link_status_t status,            // Ready from the lock monitor
    input  credit_ret_t  credit,            // Credit pulse from serializer
    output serdes_word_t raw_word,          // Every aligned word
    output serdes_word_t word_out,          // Credit-gated words
    output logic         overrun            // Sticky drop flag
);

    logic [`SERDES_WIDTH-2:0]    shift_q;   // Bits collected so far
    logic [`SERDES_WIDTH-1:0]    word_next; // Word including current bit
    logic [`SERDES_WIDTH-1:0]    word_q;    // Last completed word
    logic [`SERDES_CNT_W-1:0]    bit_cnt_q; // Position in current word
    logic [`SERDES_CREDIT_W-1:0] credit_q;  // Free serializer entries
    logic                        word_done; // Last bit of word this cycle
    logic                        send;      // Forward completed word
    logic                        drop;      // Ready but out of credit
    logic                        raw_valid_q;
    logic                        out_valid_q;
    logic                        overrun_q;

    // ***********************************************************
    // Bit collection and word boundary
    // ***********************************************************
    assign word_next = {shift_q, ctrl.data};                   // New bit at LSB
    assign word_done = (bit_cnt_q == `SERDES_CNT_W'(`SERDES_WIDTH - 1)) &&
                       !ctrl.bitslip;                          // Slip delays completion

    always_ff @(posedge clkGHz_clkbuf) begin
        shift_q <= word_next[`SERDES_WIDTH-2:0];               // Oldest bit falls off
    end

    // A slip pulse holds the counter, so the word takes one more bit
    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            bit_cnt_q <= '0;
        end else if (word_done) begin
            bit_cnt_q <= '0;                                   // Next word starts
        end else if (!ctrl.bitslip) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
        end
    end

    // ***********************************************************
    // Word strobes and credit gating
    // ***********************************************************
    assign send = word_done && status.ready && (credit_q != '0);
    assign drop = word_done && status.ready && (credit_q == '0);

    always_ff @(posedge clkGHz_clkbuf) begin
        if (word_done) begin
            word_q <= word_next;                               // Shared by both outputs
        end
    end

    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            raw_valid_q <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            raw_valid_q <= word_done;                          // Monitor sees every word
            out_valid_q <= send;
        end
    end

    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            credit_q <= `SERDES_CREDIT_W'(`CREDIT_DEPTH);      // Buffer starts empty
        end else begin
            case ({send, credit.ret})
                2'b10:   credit_q <= credit_q - 1'b1;          // Word spent one
                2'b01:   credit_q <= credit_q + 1'b1;          // Entry freed
                default: credit_q <= credit_q;                 // Both or neither
            endcase
        end
    end

    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            overrun_q <= 1'b0;
        end else if (drop) begin
            overrun_q <= 1'b1;                                 // Sticky until reset
        end
    end

    assign raw_word = '{valid: raw_valid_q, data: word_q};
    assign word_out = '{valid: out_valid_q, data: word_q};
    assign overrun  = overrun_q;

endmodule

// File: source/link_lock_monitor.sv
/* Lock detector for the deserialized stream.
   Waits out the settling period, then watches for a run of training
   words; ready latches once both hold and stays up until reset. */

`include "serdes_consts.svh"

module link_lock_monitor import serdes_word_pkg::*, serdes_ctrl_pkg::*; (
    input  logic         clkGHz_clkbuf,
    input  logic         reset_buf_n,
    input  serdes_word_t raw_word,          // Every aligned word
    output link_status_t status             // Ready to the sender and pins
);

    logic [`SETTLE_W-1:0]    settle_q;      // Saturating power-up counter
    logic [`TRAIN_RUN_W-1:0] run_q;         // Consecutive training words
    logic                    settled;
    logic                    aligned;
    logic                    is_train;
    logic                    ready_q;

    // ***********************************************************
    // Settling period
    // ***********************************************************
    assign settled = (settle_q == `SETTLE_W'(`SETTLE_CYCLES));

    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            settle_q <= '0;
        end else if (!settled) begin
            settle_q <= settle_q + 1'b1;                       // Stops at the limit
        end
    end

    // ***********************************************************
    // Training word run length
    // ***********************************************************
    assign is_train = (raw_word.data == `TRAIN_WORD);
    assign aligned  = (run_q == `TRAIN_RUN_W'(`TRAIN_COUNT));

    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            run_q <= '0;
        end else if (raw_word.valid) begin
            if (!is_train) begin
                run_q <= '0;                                   // Any other word restarts
            end else if (!aligned) begin
                run_q <= run_q + 1'b1;                         // Saturates at TRAIN_COUNT
            end
        end
    end

    // Ready rises the cycle after both conditions hold
    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            ready_q <= 1'b0;
        end else if (settled && aligned) begin
            ready_q <= 1'b1;                                   // Latched until reset
        end
    end

    // Drops are seen by the sender, which owns the overrun flag
    assign status = '{ready: ready_q, overrun: 1'b0};

endmodule

// File: source/word_serializer.sv
/* Word-to-serial converter with a small word buffer.
   Words are shifted out MSB first with data_o_en marking each bit;
   a credit pulse goes back each time a word leaves the buffer. */

`include "serdes_consts.svh"

module word_serializer import serdes_word_pkg::*; (
    input  logic         clkGHz_clkbuf,
    input  logic         reset_buf_n,
    input  serdes_word_t word_in,           // Credit-gated words
    input  logic         enable,            // Low freezes the shifter
    output credit_ret_t  credit,            // Entry freed pulse
    output logic         data_o,            // Serial data, MSB first
    output logic         data_o_en          // Marks valid output bits
);

    logic [`SERDES_WIDTH-1:0]    fifo_mem [`CREDIT_DEPTH];
    logic [`SERDES_PTR_W-1:0]    wr_ptr_q;
    logic [`SERDES_PTR_W-1:0]    rd_ptr_q;
    logic [`SERDES_CREDIT_W-1:0] count_q;   // Words held in buffer
    logic [`SERDES_WIDTH-1:0]    shift_q;   // Word being sent
    logic [`SERDES_CNT_W-1:0]    bit_cnt_q; // Bit being sent
    logic                        active_q;  // Shifter holds a word
    logic                        last_bit;
    logic                        load;      // Buffer to shifter move
    logic                        credit_q;

    // ***********************************************************
    // Word buffer
    // ***********************************************************
    always_ff @(posedge clkGHz_clkbuf) begin
        if (word_in.valid) begin
            fifo_mem[wr_ptr_q] <= word_in.data;                // Space assured by credits
        end
    end

    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (word_in.valid) begin
                wr_ptr_q <= (wr_ptr_q == `SERDES_PTR_W'(`CREDIT_DEPTH - 1)) ?
                            '0 : wr_ptr_q + 1'b1;              // Wrap at depth
            end
            if (load) begin
                rd_ptr_q <= (rd_ptr_q == `SERDES_PTR_W'(`CREDIT_DEPTH - 1)) ?
                            '0 : rd_ptr_q + 1'b1;
            end
            case ({word_in.valid, load})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;                   // Push and pop cancel
            endcase
        end
    end

    // ***********************************************************
    // Shifter
    // ***********************************************************
    assign last_bit = active_q && (bit_cnt_q == `SERDES_CNT_W'(`SERDES_WIDTH - 1));
    assign load     = enable && (count_q != '0) && (!active_q || last_bit);

    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            active_q  <= 1'b0;
            bit_cnt_q <= '0;
            credit_q  <= 1'b0;
        end else begin
            credit_q <= load;                                  // One pulse per word taken
            if (load) begin
                active_q  <= 1'b1;                             // Back to back with last word
                bit_cnt_q <= '0;
            end else if (enable && active_q) begin
                if (last_bit) begin
                    active_q <= 1'b0;                          // Buffer empty, go idle
                end else begin
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clkGHz_clkbuf) begin
        if (load) begin
            shift_q <= fifo_mem[rd_ptr_q];
        end else if (enable && active_q) begin
            shift_q <= {shift_q[`SERDES_WIDTH-2:0], 1'b0};     // Next bit to MSB
        end
    end

    assign data_o_en = active_q && enable;                     // Stands in for tri-state
    assign data_o    = data_o_en && shift_q[`SERDES_WIDTH-1];
    assign credit    = '{ret: credit_q};

endmodule

// File: source/serdes_loopback_top.sv
/* Top level of the serial loopback design.
   Registers the pins, then deserializes, checks lock and
   re-serializes the aligned words back out on data_o. */

module serdes_loopback_top import serdes_word_pkg::*, serdes_ctrl_pkg::*; (
    input  logic clkGHz_clkbuf,
    input  logic reset_buf_n,               // Async, active low
    input  logic data_i,                    // Serial input stream
    input  logic enable_n,                  // Output enable, active low
    input  logic bitslip_ctrl_n,            // Falling edge requests a slip
    output logic data_o,                    // Serial output stream
    output logic data_o_en,                 // Output bit valid
    output logic ready,                     // Link locked
    output logic overrun                    // Sticky word drop
);

    ctrl_sync_t   ctrl_q;                   // Registered controls
    logic         bitslip_n_q;              // Previous bitslip_ctrl_n
    serdes_word_t raw_word;                 // Deserializer to monitor
    serdes_word_t word_xfer;                // Deserializer to serializer
    link_status_t lock_status;
    credit_ret_t  credit;

    // ***********************************************************
    // Pin registers
    // ***********************************************************
    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            ctrl_q      <= '0;
            bitslip_n_q <= 1'b1;                               // Idle high
        end else begin
            bitslip_n_q    <= bitslip_ctrl_n;
            ctrl_q.data    <= data_i;
            ctrl_q.enable  <= ~enable_n;                       // Now active high
            ctrl_q.bitslip <= bitslip_n_q & ~bitslip_ctrl_n;   // Falling edge only
        end
    end

    // ***********************************************************
    // Data path
    // ***********************************************************
    deser_bitslip u_deser_bitslip (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .ctrl          (ctrl_q),
        .status        (lock_status),
        .credit        (credit),
        .raw_word      (raw_word),
        .word_out      (word_xfer),
        .overrun       (overrun)                               // Straight to the pin
    );

    link_lock_monitor u_link_lock_monitor (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .raw_word      (raw_word),
        .status        (lock_status)
    );

    word_serializer u_word_serializer (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .word_in       (word_xfer),
        .enable        (ctrl_q.enable),
        .credit        (credit),
        .data_o        (data_o),
        .data_o_en     (data_o_en)
    );

    assign ready = lock_status.ready;

endmodule

// File: tests/tb_serdes_ref.svh
/* Reference model for the loopback testbench, included inside the testbench module.
   Builds the input bit stream, the expected slip count and the expected words. */

`ifndef TB_SERDES_REF_SVH
`define TB_SERDES_REF_SVH

// ***********************************************************
// Input stream
// ***********************************************************

// With no slip the first word boundary sits two bits before the first driven bit
localparam int NATIVE_PHASE = 8;

// Filler, then training words, then payload from payload_from_w onward
function automatic logic stream_bit(input int p);
    int          w;
    int          pos;
    logic [`SERDES_WIDTH-1:0] word;
    if (p < offset_k) begin
        return fill_word[p];                                   // Random lead-in
    end
    w    = (p - offset_k) / `SERDES_WIDTH;
    pos  = (p - offset_k) % `SERDES_WIDTH;
    word = (w >= payload_from_w) ? payload[(w - payload_from_w) & 255] : `TRAIN_WORD;
    return word[`SERDES_WIDTH-1-pos];                          // MSB first on the wire
endfunction

// Each slip moves the boundary one bit later
function automatic int expected_slips(input int k);
    return (k + `SERDES_WIDTH - NATIVE_PHASE) % `SERDES_WIDTH;
endfunction

// ***********************************************************
// Expected output
// ***********************************************************

// Without drops the output is the payload in order
function automatic void build_expected();
    for (int i = 0; i < 256; i++) begin
        exp_w[i] = payload[i];
    end
endfunction

// True when got_w[0..n-1] appears in order within the payload
function automatic bit is_in_order_subset(input int n);
    int j;
    j = 0;
    for (int i = 0; i < n; i++) begin
        while (j < 256 && payload[j] != got_w[i]) begin
            j++;                                               // Skip dropped words
        end
        if (j == 256) begin
            return 1'b0;
        end
        j++;
    end
    return 1'b1;
endfunction

`endif

// File: tests/tb_serdes_loopback.sv
/* Testbench for the serial loopback top level.
   Locks the link by stepping bitslips, checks payload loopback,
   back-pressure with overrun, and relock after a mid-run reset. */

`include "serdes_consts.svh"

module tb_serdes_loopback;

    localparam int STIM_CYCLES = 3000;                         // Two lock rounds plus traffic
    localparam int CYCLE_LIMIT = 4 * STIM_CYCLES;

    logic clkGHz_clkbuf;
    logic reset_buf_n;
    logic data_i;
    logic enable_n;
    logic bitslip_ctrl_n;
    logic data_o;
    logic data_o_en;
    logic ready;
    logic overrun;

    logic [`SERDES_WIDTH-1:0] payload [256];
    logic [`SERDES_WIDTH-1:0] exp_w   [256];
    logic [`SERDES_WIDTH-1:0] got_w   [256];
    logic [`SERDES_WIDTH-1:0] fill_word;
    logic [`SERDES_WIDTH-1:0] cur_word;
    int offset_k;
    int payload_from_w;
    int stream_p;
    int got_n;
    int bit_n;
    int exact_limit;
    int value_errs;
    int other_errs;
    int cycles;
    bit skip_train;

    `include "tb_serdes_ref.svh"

    serdes_loopback_top u_serdes_loopback_top (
        .clkGHz_clkbuf  (clkGHz_clkbuf),
        .reset_buf_n    (reset_buf_n),
        .data_i         (data_i),
        .enable_n       (enable_n),
        .bitslip_ctrl_n (bitslip_ctrl_n),
        .data_o         (data_o),
        .data_o_en      (data_o_en),
        .ready          (ready),
        .overrun        (overrun)
    );

    // ***********************************************************
    // Clock, cycle limit and stream generator
    // ***********************************************************
    always #5 clkGHz_clkbuf = ~clkGHz_clkbuf;

    always @(posedge clkGHz_clkbuf) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped: cycle limit reached before the tests finished");
            $display("tests failed");
            $finish;
        end
    end

    always @(posedge clkGHz_clkbuf) begin
        if (!reset_buf_n) begin
            stream_p = 0;                                      // Restart with the link
            data_i <= 1'b0;
        end else begin
            data_i <= stream_bit(stream_p);
            stream_p++;
        end
    end

    // ***********************************************************
    // Output capture and compare
    // ***********************************************************
    always @(posedge clkGHz_clkbuf) begin
        if (!reset_buf_n) begin
            bit_n      = 0;
            got_n      = 0;
            skip_train = 1'b1;
        end else if (data_o_en) begin
            cur_word = {cur_word[`SERDES_WIDTH-2:0], data_o};
            bit_n++;
            if (bit_n == `SERDES_WIDTH) begin
                bit_n = 0;
                if (!(skip_train && cur_word == `TRAIN_WORD)) begin   // Leftover training
                    skip_train = 1'b0;
                    if (got_n < exact_limit) begin
                        assert (cur_word == exp_w[got_n]) else begin
                            value_errs++;
                            $display("ERROR %0t: word %0d is %h, expected %h",
                                     $time, got_n, cur_word, exp_w[got_n]);
                        end
                    end
                    got_w[got_n & 255] = cur_word;
                    got_n++;
                end
            end
        end
    end

    // ***********************************************************
    // Stimulus tasks
    // ***********************************************************
    task automatic flag_low(input logic sig, input string what);
        assert (sig == 1'b0) else begin
            other_errs++;
            $display("ERROR %0t: %s is high where it should be low", $time, what);
        end
    endtask

    task automatic apply_reset();
        payload_from_w = 1 << 30;                              // Training only
        offset_k       = $urandom % `SERDES_WIDTH;
        fill_word      = `SERDES_WIDTH'($urandom);
        @(posedge clkGHz_clkbuf);
        reset_buf_n <= 1'b0;
        repeat (2) @(posedge clkGHz_clkbuf);
        reset_buf_n <= 1'b1;
    endtask

    task automatic pulse_bitslip();
        @(posedge clkGHz_clkbuf);
        bitslip_ctrl_n <= 1'b0;
        @(posedge clkGHz_clkbuf);
        bitslip_ctrl_n <= 1'b1;
    endtask

    // Step slips until ready, then switch the stream to payload
    task automatic lock_link();
        int slips;
        slips = 0;
        repeat (250) begin
            @(posedge clkGHz_clkbuf);
            flag_low(ready, "ready during settling");
            flag_low(overrun, "overrun before lock");
            flag_low(data_o_en, "data_o_en before lock");
        end
        repeat (50) @(posedge clkGHz_clkbuf);
        while (!ready && slips < 2 * `SERDES_WIDTH) begin
            pulse_bitslip();
            slips++;
            // Fewer than a full run of aligned words fits in this window
            repeat ((`TRAIN_COUNT - 1) * `SERDES_WIDTH) begin
                @(posedge clkGHz_clkbuf);
                flag_low(ready, "ready before a full run of training words");
            end
            repeat (40) @(posedge clkGHz_clkbuf);              // Last word plus slack
        end
        assert (ready && slips == expected_slips(offset_k)) else begin
            other_errs++;
            $display("Lock took %0d bitslips at offset %0d, expected %0d (ready=%b)",
                     slips, offset_k, expected_slips(offset_k), ready);
        end
        payload_from_w = (stream_p - offset_k) / `SERDES_WIDTH + 3;
    endtask

    task automatic wait_words(input int n);
        while (got_n < n) begin
            @(posedge clkGHz_clkbuf);                          // Cycle limit bounds this
        end
    endtask

    // ***********************************************************
    // Main sequence
    // ***********************************************************
    initial begin
        int n_before;
        clkGHz_clkbuf  = 1'b0;
        reset_buf_n    = 1'b0;
        data_i         = 1'b0;
        enable_n       = 1'b0;
        bitslip_ctrl_n = 1'b1;
        value_errs     = 0;
        other_errs     = 0;
        cycles         = 0;
        exact_limit    = 1 << 30;
        void'($urandom(32'hc55543db));
        for (int i = 0; i < 256; i++) begin
            do begin
                payload[i] = `SERDES_WIDTH'($urandom);
            end while (payload[i] == `TRAIN_WORD);             // Keeps skip logic exact
        end
        build_expected();

        apply_reset();
        lock_link();
        wait_words(8);
        flag_low(overrun, "overrun with enable asserted");

        // Back-pressure, only the words that fit in credits stay exact
        n_before    = got_n;
        exact_limit = n_before + `CREDIT_DEPTH;
        @(posedge clkGHz_clkbuf);
        enable_n <= 1'b1;
        @(posedge clkGHz_clkbuf);
        repeat (80) begin
            @(posedge clkGHz_clkbuf);
            flag_low(data_o_en, "data_o_en while enable_n is high");
        end
        assert (overrun) else begin
            other_errs++;
            $display("Overrun did not set while the output was held off");
        end
        enable_n <= 1'b0;
        wait_words(n_before + `CREDIT_DEPTH + 4);
        assert (is_in_order_subset(got_n)) else begin
            other_errs++;
            $display("Output after back-pressure is not an in-order subset of the payload");
        end

        // Relock after a reset in the middle of traffic
        exact_limit = 1 << 30;
        apply_reset();
        @(posedge clkGHz_clkbuf);
        flag_low(ready, "ready after reset");
        flag_low(overrun, "overrun after reset");
        lock_link();
        wait_words(6);

        $display("Errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+source
+incdir+tests
source/serdes_word_pkg.sv
source/serdes_ctrl_pkg.sv
source/deser_bitslip.sv
source/link_lock_monitor.sv
source/word_serializer.sv
source/serdes_loopback_top.sv
tests/tb_serdes_loopback.sv

// File: Makefile
# Verilator build for the serial loopback testbench

VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -j 0
TOP        ?= tb_serdes_loopback
FLIST      ?= flist.f
BUILD_DIR  ?= obj_dir
PASS_MSG   := all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
